// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = mpu_tb
FILELIST  = mpu.f
PASS_MSG  = Finished with no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// ==== include/mpu_macros.svh ====
// Matrix unit size macros
`ifndef MPU_MACROS_SVH
`define MPU_MACROS_SVH

// Side of every square matrix
`define MPU_DIM 3

// Matrices held in the register file
`define MPU_NUM_MATS 4

// Bits per element
`define MPU_ELEM_W 32

`endif

// ==== mpu.f ====
+incdir+include
src/mpu_data_pkg.sv
src/mpu_ctrl_pkg.sv
src/mpu_regfile.sv
src/mpu_sequencer.sv
src/mpu_mac_cluster.sv
src/mpu_add_cluster.sv
src/mpu_collector.sv
src/mpu_top.sv
testbench/mpu_tb.sv

// ==== src/mpu_add_cluster.sv ====
// Element-wise add and subtract cluster
`timescale 1ns/1ns
`include "mpu_macros.svh"

module mpu_add_cluster
    import mpu_data_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        start_i,
    input  logic        sub_i,     // Subtract B from A
    input  mpu_matrix_t mat_a_i,
    input  mpu_matrix_t mat_b_i,
    output mpu_result_t result_o
);

    mpu_matrix_t sum_q;
    logic [`MPU_DIM*`MPU_DIM-1:0] ready;

    // All nine cells in one cycle
    always_ff @(posedge clk) begin
        if (start_i) begin
            for (int i = 0; i < `MPU_DIM; i++) begin
                for (int j = 0; j < `MPU_DIM; j++) begin
                    sum_q[i][j] <= sub_i ? mat_a_i[i][j] - mat_b_i[i][j]
                                         : mat_a_i[i][j] + mat_b_i[i][j];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) ready <= '0;
        else     ready <= start_i ? '1 : '0;  // Single-cycle pulse
    end

    assign result_o.data  = sum_q;
    assign result_o.ready = ready;

endmodule

// ==== src/mpu_collector.sv ====
// Result collector and write-back
`timescale 1ns/1ns
`include "mpu_macros.svh"

module mpu_collector
    import mpu_data_pkg::*;
    import mpu_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  mpu_result_t mac_result_i,
    input  mpu_result_t add_result_i,
    output mpu_wb_t     wb_o,
    output logic        finished_o    // One cycle after the last write
);

    localparam int N_ELEM = `MPU_DIM * `MPU_DIM;

    collector_state_e  state, next_state;
    logic [N_ELEM-1:0] ready;
    logic [N_ELEM-1:0] mask;      // Elements captured so far
    logic              mask_full;
    logic              last;
    mpu_pos_t          row, col;
    mpu_matrix_t       buffer;

    assign ready     = mac_result_i.ready | add_result_i.ready;
    assign mask_full = &(mask | ready);
    assign last      = (row == mpu_pos_t'(`MPU_DIM - 1)) &&
                       (col == mpu_pos_t'(`MPU_DIM - 1));

    // Capture whichever cluster flags each element
    always_ff @(posedge clk) begin
        for (int i = 0; i < `MPU_DIM; i++) begin
            for (int j = 0; j < `MPU_DIM; j++) begin
                if (mac_result_i.ready[i*`MPU_DIM + j]) begin
                    buffer[i][j] <= mac_result_i.data[i][j];
                end
                else if (add_result_i.ready[i*`MPU_DIM + j]) begin
                    buffer[i][j] <= add_result_i.data[i][j];
                end
            end
        end
    end

    always_comb begin
        next_state = state;
        unique case (state)
            COLLECTOR_IDLE: begin
                if (mask_full) next_state = COLLECTOR_WRITE;
            end
            COLLECTOR_WRITE: begin
                if (last) next_state = COLLECTOR_IDLE;
            end
            default: next_state = COLLECTOR_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= COLLECTOR_IDLE;
            mask       <= '0;
            row        <= '0;
            col        <= '0;
            finished_o <= 1'b0;
        end
        else begin
            state      <= next_state;
            finished_o <= (state == COLLECTOR_WRITE) && last;

            if (state == COLLECTOR_IDLE) begin
                mask <= mask_full ? '0 : (mask | ready);  // Cleared on entry to write
            end

            // Row-major walk
            if (state == COLLECTOR_WRITE) begin
                if (col == mpu_pos_t'(`MPU_DIM - 1)) begin
                    col <= '0;
                    row <= last ? '0 : row + 1'b1;
                end
                else begin
                    col <= col + 1'b1;
                end
            end
        end
    end

    always_comb begin
        wb_o.we   = (state == COLLECTOR_WRITE);
        wb_o.row  = row;
        wb_o.col  = col;
        wb_o.data = buffer[row][col];
    end

    // Sequencer starts exactly one cluster per command
    a_one_cluster: assert property (@(posedge clk) disable iff (rst)
        !((|mac_result_i.ready) && (|add_result_i.ready)));

    // Next results may only land once write-back has drained
    a_no_ready_in_write: assert property (@(posedge clk) disable iff (rst)
        state == COLLECTOR_WRITE |-> ready == '0);

endmodule

// ==== src/mpu_ctrl_pkg.sv ====
// Matrix unit control types
package mpu_ctrl_pkg;

    import mpu_data_pkg::*;

    typedef enum logic [1:0] {
        MPU_MUL = 2'd0,  // Matrix product
        MPU_ADD = 2'd1,
        MPU_SUB = 2'd2
    } mpu_opcode_e;

    typedef struct packed {
        mpu_opcode_e  opcode;
        mpu_mat_idx_t src_a;
        mpu_mat_idx_t src_b;
        mpu_mat_idx_t dst;
    } mpu_cmd_t;

    typedef enum logic {
        SEQ_IDLE,
        SEQ_RUN        // Command in flight until write-back ends
    } seq_state_e;

    typedef enum logic {
        COLLECTOR_IDLE,
        COLLECTOR_WRITE
    } collector_state_e;

endpackage

// ==== src/mpu_data_pkg.sv ====
// Matrix data types
`include "mpu_macros.svh"

package mpu_data_pkg;

    // Signed element with wraparound arithmetic
    typedef logic signed [`MPU_ELEM_W-1:0] mpu_elem_t;

    typedef logic [$clog2(`MPU_DIM)-1:0] mpu_pos_t;           // Row or column
    typedef logic [$clog2(`MPU_NUM_MATS)-1:0] mpu_mat_idx_t;  // Register file slot

    // Indexed as [row][col]
    typedef mpu_elem_t [`MPU_DIM-1:0][`MPU_DIM-1:0] mpu_matrix_t;

    // Cluster output, ready bit per element at row*DIM+col
    typedef struct packed {
        mpu_matrix_t                      data;
        logic [`MPU_DIM*`MPU_DIM-1:0]     ready;
    } mpu_result_t;

    // One element written back into the destination
    typedef struct packed {
        logic      we;
        mpu_pos_t  row;
        mpu_pos_t  col;
        mpu_elem_t data;
    } mpu_wb_t;

endpackage

// ==== src/mpu_mac_cluster.sv ====
// Multiply-accumulate cluster
`timescale 1ns/1ns
`include "mpu_macros.svh"

module mpu_mac_cluster
    import mpu_data_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        start_i,
    input  mpu_matrix_t mat_a_i,
    input  mpu_matrix_t mat_b_i,
    output mpu_result_t result_o
);

    localparam int LAST_STEP = `MPU_DIM - 1;

    logic                         active;
    logic                         launch;
    mpu_pos_t                     step;   // Next k while active
    mpu_pos_t                     k;      // Inner index used this cycle
    mpu_matrix_t                  acc;
    logic [`MPU_DIM*`MPU_DIM-1:0] ready;

    // Starts during a run are ignored
    assign launch = start_i && !active;
    assign k      = step;

    // Step counter and ready strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
            step   <= '0;
            ready  <= '0;
        end
        else begin
            ready <= '0;
            if (launch) begin
                active <= 1'b1;
                step   <= mpu_pos_t'(1);
            end
            else if (active) begin
                if (step == mpu_pos_t'(LAST_STEP)) begin
                    active <= 1'b0;
                    step   <= '0;
                    ready  <= '1;  // All nine done together
                end
                else begin
                    step <= step + 1'b1;
                end
            end
        end
    end

    // One cell per output element
    for (genvar i = 0; i < `MPU_DIM; i++) begin : g_row
        for (genvar j = 0; j < `MPU_DIM; j++) begin : g_col
            mpu_elem_t product;
            mpu_elem_t cell_acc;

            assign product = mat_a_i[i][k] * mat_b_i[k][j];  // Low 32 bits kept

            always_ff @(posedge clk) begin
                if (launch) begin
                    cell_acc <= product;
                end
                else if (active) begin
                    cell_acc <= cell_acc + product;
                end
            end

            assign acc[i][j] = cell_acc;
        end
    end

    assign result_o.data  = acc;
    assign result_o.ready = ready;

endmodule

// ==== src/mpu_regfile.sv ====
// Matrix register file
`timescale 1ns/1ns
`include "mpu_macros.svh"

module mpu_regfile
    import mpu_data_pkg::*;
(
    input  logic         clk,
    input  logic         rst,

    // Operand and destination slots from the sequencer
    input  mpu_mat_idx_t src_a_i,
    input  mpu_mat_idx_t src_b_i,
    input  mpu_mat_idx_t dst_i,

    input  mpu_wb_t      wb_i,          // From collector

    // Host access
    input  logic         host_we_i,
    input  mpu_mat_idx_t host_mat_i,
    input  mpu_pos_t     host_row_i,
    input  mpu_pos_t     host_col_i,
    input  mpu_elem_t    host_wdata_i,
    output mpu_elem_t    host_rdata_o,

    output mpu_matrix_t  mat_a_o,
    output mpu_matrix_t  mat_b_o
);

    mpu_matrix_t mats [`MPU_NUM_MATS];

    // Write port shared by collector and host
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int m = 0; m < `MPU_NUM_MATS; m++) begin
                mats[m] <= '0;
            end
        end
        else if (wb_i.we) begin
            mats[dst_i][wb_i.row][wb_i.col] <= wb_i.data;
        end
        else if (host_we_i) begin
            mats[host_mat_i][host_row_i][host_col_i] <= host_wdata_i;
        end
    end

    // Host read, one cycle latency
    always_ff @(posedge clk) begin
        host_rdata_o <= mats[host_mat_i][host_row_i][host_col_i];
    end

    assign mat_a_o = mats[src_a_i];  // Whole operands, no latency
    assign mat_b_o = mats[src_b_i];

    // Host must stay off the port while a command writes back
    a_single_writer: assert property (@(posedge clk) disable iff (rst)
        !(wb_i.we && host_we_i));

endmodule

// ==== src/mpu_sequencer.sv ====
// Command sequencer
`timescale 1ns/1ns

module mpu_sequencer
    import mpu_data_pkg::*;
    import mpu_ctrl_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         cmd_valid_i,
    input  mpu_cmd_t     cmd_i,
    input  logic         finished_i,   // Last element written back
    output logic         mac_start_o,
    output logic         add_start_o,
    output logic         sub_o,
    output mpu_mat_idx_t src_a_o,
    output mpu_mat_idx_t src_b_o,
    output mpu_mat_idx_t dst_o,
    output logic         busy_o
);

    seq_state_e state;
    mpu_cmd_t   cmd_q;
    logic       accept;

    // Strobes during a run are dropped
    assign accept = cmd_valid_i && (state == SEQ_IDLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= SEQ_IDLE;
            cmd_q       <= '0;
            mac_start_o <= 1'b0;
            add_start_o <= 1'b0;
        end
        else begin
            // One start pulse the cycle after acceptance
            mac_start_o <= accept && (cmd_i.opcode == MPU_MUL);
            add_start_o <= accept && (cmd_i.opcode inside {MPU_ADD, MPU_SUB});

            unique case (state)
                SEQ_IDLE: begin
                    if (accept) begin
                        cmd_q <= cmd_i;
                        state <= SEQ_RUN;
                    end
                end
                SEQ_RUN: begin
                    if (finished_i) state <= SEQ_IDLE;
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    assign sub_o   = (cmd_q.opcode == MPU_SUB);  // Held for the whole run
    assign src_a_o = cmd_q.src_a;
    assign src_b_o = cmd_q.src_b;
    assign dst_o   = cmd_q.dst;
    assign busy_o  = (state == SEQ_RUN);

    // Collector only finishes write-backs this block started
    a_finish_in_run: assert property (@(posedge clk) disable iff (rst)
        finished_i |-> state == SEQ_RUN);

endmodule

// ==== src/mpu_top.sv ====
// Matrix processing unit top level
`timescale 1ns/1ns

module mpu_top
    import mpu_data_pkg::*;
    import mpu_ctrl_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         cmd_valid_i,
    input  mpu_cmd_t     cmd_i,
    input  logic         host_we_i,
    input  mpu_mat_idx_t host_mat_i,
    input  mpu_pos_t     host_row_i,
    input  mpu_pos_t     host_col_i,
    input  mpu_elem_t    host_wdata_i,
    output mpu_elem_t    host_rdata_o,
    output logic         busy_o,
    output logic         done_o
);

    mpu_mat_idx_t src_a, src_b, dst;
    mpu_matrix_t  mat_a, mat_b;
    logic         mac_start, add_start, sub;
    mpu_result_t  mac_result, add_result;
    mpu_wb_t      wb;
    logic         finished;

    mpu_regfile u_regfile (
        .clk, .rst,
        .src_a_i(src_a), .src_b_i(src_b), .dst_i(dst),
        .wb_i(wb),
        .host_we_i, .host_mat_i, .host_row_i, .host_col_i,
        .host_wdata_i, .host_rdata_o,
        .mat_a_o(mat_a), .mat_b_o(mat_b)
    );

    mpu_sequencer u_sequencer (
        .clk, .rst, .cmd_valid_i, .cmd_i,
        .finished_i(finished),
        .mac_start_o(mac_start), .add_start_o(add_start), .sub_o(sub),
        .src_a_o(src_a), .src_b_o(src_b), .dst_o(dst),
        .busy_o
    );

    mpu_mac_cluster u_mac (
        .clk, .rst, .start_i(mac_start),
        .mat_a_i(mat_a), .mat_b_i(mat_b),
        .result_o(mac_result)
    );

    mpu_add_cluster u_add (
        .clk, .rst, .start_i(add_start), .sub_i(sub),
        .mat_a_i(mat_a), .mat_b_i(mat_b),
        .result_o(add_result)
    );

    mpu_collector u_collector (
        .clk, .rst,
        .mac_result_i(mac_result), .add_result_i(add_result),
        .wb_o(wb), .finished_o(finished)
    );

    assign done_o = finished;  // Same cycle busy drops

endmodule

// ==== testbench/mpu_tb.sv ====
// Matrix unit testbench
`timescale 1ns/1ns
`include "mpu_macros.svh"

module mpu_tb
    import mpu_data_pkg::*;
    import mpu_ctrl_pkg::*;
();

    localparam int N_ELEM          = `MPU_DIM * `MPU_DIM;
    localparam int READ_ALL_CYCLES = 2 * `MPU_NUM_MATS * N_ELEM;  // Two cycles per host read
    localparam int CMD_CYCLES      = 16;                          // Issue plus MUL latency
    localparam int TIMEOUT_CYCLES  = 5 + `MPU_NUM_MATS * N_ELEM + 6 * READ_ALL_CYCLES
                                     + 6 * CMD_CYCLES + CMD_CYCLES + 100;

    logic         clk;
    logic         rst;
    logic         cmd_valid_i;
    mpu_cmd_t     cmd_i;
    logic         host_we_i;
    mpu_mat_idx_t host_mat_i;
    mpu_pos_t     host_row_i;
    mpu_pos_t     host_col_i;
    mpu_elem_t    host_wdata_i;
    mpu_elem_t    host_rdata_o;
    logic         busy_o;
    logic         done_o;

    mpu_matrix_t  model [`MPU_NUM_MATS];  // Expected register file
    logic [31:0]  lfsr = 32'h606c;
    int           cycle = 0;
    int           t0;                     // Cycle count just after acceptance
    int           errors = 0;
    int           test_errors;
    int           tests = 0;
    string        test_name;

    mpu_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    initial begin
        while (cycle < TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout: run did not end within %0d cycles", TIMEOUT_CYCLES);
        $display("Finished with errors");
        $finish;
    end

    task automatic report_mismatch(input string what, input longint expected,
                                   input longint actual);
        errors++;
        test_errors++;
        $display("Mismatch in %s: %s expected %0d, actual %0d", test_name, what, expected, actual);
    endtask

    task automatic report_error(input string msg);
        errors++;
        test_errors++;
        $display("Error in %s: %s", test_name, msg);
    endtask

    // Done is a single-cycle pulse that closes a run
    a_done_pulse: assert property (@(posedge clk) disable iff (rst) done_o |=> !done_o)
        else report_error("done_o stayed high for more than one cycle");
    a_done_in_run: assert property (@(posedge clk) disable iff (rst) done_o |-> busy_o)
        else report_error("done_o pulsed with no command in flight");

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic mpu_elem_t rand_elem();
        mpu_elem_t v;
        for (int b = 0; b < `MPU_ELEM_W; b++) begin
            lfsr = lfsr_next(lfsr);  // One step per bit
            v[b] = lfsr[0];
        end
        return v;
    endfunction

    // Row by column, low 32 bits of every term
    function automatic mpu_matrix_t mat_mul(input mpu_matrix_t a, input mpu_matrix_t b);
        mpu_matrix_t p;
        p = '0;
        for (int i = 0; i < `MPU_DIM; i++) begin
            for (int j = 0; j < `MPU_DIM; j++) begin
                for (int k = 0; k < `MPU_DIM; k++) begin
                    p[i][j] = p[i][j] + a[i][k] * b[k][j];
                end
            end
        end
        return p;
    endfunction

    function automatic mpu_matrix_t elementwise(input mpu_matrix_t a, input mpu_matrix_t b,
                                                input bit sub);
        mpu_matrix_t s;
        for (int i = 0; i < `MPU_DIM; i++) begin
            for (int j = 0; j < `MPU_DIM; j++) begin
                s[i][j] = sub ? a[i][j] - b[i][j] : a[i][j] + b[i][j];
            end
        end
        return s;
    endfunction

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests++;
        $display("Test %-18s %s", test_name, (test_errors == 0) ? "passed" : "failed");
    endtask

    task automatic load_random(input int m);
        mpu_elem_t v;
        for (int r = 0; r < `MPU_DIM; r++) begin
            for (int c = 0; c < `MPU_DIM; c++) begin
                v = rand_elem();
                model[m][r][c] = v;
                @(posedge clk);
                host_we_i    <= 1'b1;
                host_mat_i   <= mpu_mat_idx_t'(m);
                host_row_i   <= mpu_pos_t'(r);
                host_col_i   <= mpu_pos_t'(c);
                host_wdata_i <= v;
            end
        end
        @(posedge clk);
        host_we_i <= 1'b0;
    endtask

    // Reads every element of every matrix through the host port
    task automatic check_all();
        for (int m = 0; m < `MPU_NUM_MATS; m++) begin
            for (int r = 0; r < `MPU_DIM; r++) begin
                for (int c = 0; c < `MPU_DIM; c++) begin
                    @(posedge clk);
                    host_mat_i <= mpu_mat_idx_t'(m);
                    host_row_i <= mpu_pos_t'(r);
                    host_col_i <= mpu_pos_t'(c);
                    @(posedge clk);  // Registered read data
                    @(negedge clk);
                    assert (host_rdata_o == model[m][r][c])
                        else report_mismatch($sformatf("M%0d[%0d][%0d]", m, r, c),
                                             model[m][r][c], host_rdata_o);
                end
            end
        end
    endtask

    task automatic issue(input mpu_opcode_e op, input int a, input int b, input int d);
        @(posedge clk);
        cmd_valid_i <= 1'b1;
        cmd_i       <= '{opcode: op, src_a: mpu_mat_idx_t'(a), src_b: mpu_mat_idx_t'(b),
                         dst: mpu_mat_idx_t'(d)};
        @(posedge clk);  // Accepted here, unit idle
        cmd_valid_i <= 1'b0;
        @(negedge clk);
        t0 = cycle;
    endtask

    task automatic wait_done(input int exp_edges);
        while (!done_o) @(negedge clk);
        // Pulse gets sampled on the edge after this point
        assert (cycle - t0 + 1 == exp_edges)
            else report_mismatch("done latency", exp_edges, cycle - t0 + 1);
    endtask

    task automatic run_cmd(input mpu_opcode_e op, input int a, input int b, input int d,
                           input bit stray);
        mpu_matrix_t expected;
        expected = (op == MPU_MUL) ? mat_mul(model[a], model[b])
                                   : elementwise(model[a], model[b], op == MPU_SUB);
        issue(op, a, b, d);
        if (stray) begin
            @(posedge clk);
            @(posedge clk);
            cmd_valid_i <= 1'b1;     // Busy, must be dropped
            cmd_i       <= '{opcode: MPU_ADD, src_a: mpu_mat_idx_t'(0),
                             src_b: mpu_mat_idx_t'(1), dst: mpu_mat_idx_t'(3)};
            @(posedge clk);
            cmd_valid_i <= 1'b0;
        end
        wait_done((op == MPU_MUL) ? 14 : 12);
        model[d] = expected;
    endtask

    initial begin
        rst          = 1'b1;
        cmd_valid_i  = 1'b0;
        cmd_i        = '0;
        host_we_i    = 1'b0;
        host_mat_i   = '0;
        host_row_i   = '0;
        host_col_i   = '0;
        host_wdata_i = '0;
        for (int m = 0; m < `MPU_NUM_MATS; m++) model[m] = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        start_test("reset_and_host");
        @(negedge clk);
        assert (!busy_o) else report_mismatch("busy_o", 0, busy_o);
        assert (!done_o) else report_mismatch("done_o", 0, done_o);
        for (int m = 0; m < `MPU_NUM_MATS; m++) load_random(m);
        check_all();
        end_test();

        start_test("mul");
        run_cmd(MPU_MUL, 0, 1, 2, 1'b0);
        check_all();
        end_test();

        start_test("add");
        run_cmd(MPU_ADD, 2, 3, 0, 1'b0);
        check_all();
        end_test();

        start_test("sub_in_place");
        run_cmd(MPU_SUB, 1, 0, 1, 1'b0);  // Destination is source A
        check_all();
        end_test();

        start_test("strobe_while_busy");
        run_cmd(MPU_MUL, 3, 0, 2, 1'b1);
        repeat (CMD_CYCLES) begin
            @(negedge clk);
            assert (!done_o) else report_error("second done_o after an ignored command");
        end
        check_all();
        end_test();

        start_test("back_to_back");
        run_cmd(MPU_ADD, 0, 1, 3, 1'b0);
        run_cmd(MPU_SUB, 3, 2, 0, 1'b0);  // Issued the cycle after done
        check_all();
        end_test();

        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end
        else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
